// ==== design/message_rom.sv ====
`include "status_consts.svh"

module message_rom (
   input  logic                  clk,
   input  status_pkg::msg_id_t   msg_id,
   input  logic [`MSG_IDX_W-1:0] char_index,
   output logic [`CHAR_W-1:0]    msg_char
);
   import status_pkg::*;

   localparam int SLOT_BITS = `MSG_SLOT * `CHAR_W;

   logic [SLOT_BITS-1:0] slot;

   // AT row col, padded label, terminator fill
   function automatic logic [SLOT_BITS-1:0] at_line(input int row,
                                                    input logic [8*`MSG_LEN-1:0] label);
      return {`CODE_AT, 8'(row), 8'(`LINE_COL), label, {(`MSG_SLOT - 11){`MSG_END}}};
   endfunction

   // Status text always five characters wide
   function automatic logic [SLOT_BITS-1:0] status_text(input logic [39:0] text);
      return {text, {(`MSG_SLOT - 5){`MSG_END}}};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Message table
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      case (msg_id)
         msg_home:  slot = {`CODE_HOME, {(`MSG_SLOT - 1){`MSG_END}}};
         msg_board: slot = at_line(`ROW_BOARD, "BOARD   ");
         msg_mem:   slot = at_line(`ROW_MEM, "MEM     ");
         msg_sd:    slot = at_line(`ROW_SD, "SD      ");
         msg_joy:   slot = at_line(`ROW_JOY, "JOY1    ");
         msg_wait:  slot = status_text("wait ");
         msg_ok:    slot = status_text("OK   ");
         msg_error: slot = status_text("ERROR");
         default:   slot = {`MSG_SLOT{`MSG_END}};  // Empty slot
      endcase
   end

   // First character sits in the top byte
   always_ff @(posedge clk) begin
      msg_char <= slot[SLOT_BITS - 1 - `CHAR_W * char_index -: `CHAR_W];
   end

endmodule

// ==== design/report_sequencer.sv ====
`include "status_consts.svh"

module report_sequencer (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`BOARD_ID_W-1:0] board_id,
   input  logic                   mem_busy,
   input  logic                   mem_ok,
   input  logic                   sd_busy,
   input  logic                   sd_ok,
   input  logic [`JOY_KEYS-1:0]   joy_md,
   input  logic                   busy,
   input  logic [`CHAR_W-1:0]     msg_char,
   output status_pkg::msg_id_t    msg_id,
   output logic [`MSG_IDX_W-1:0]  char_index,
   output logic [`CHAR_W-1:0]     chr,
   output logic                   chr_we,
   output logic                   report_done
);
   import status_pkg::*;

   // Key order on screen and the joy_md bit behind each letter
   localparam logic [8*`JOY_KEYS-1:0] KEY_LETTERS = "UDLR123XYZSM";
   localparam logic [4*`JOY_KEYS-1:0] KEY_BITS =
      {4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd10, 4'd9, 4'd8, 4'd7, 4'd11};

   report_state_t          state;
   report_state_t          ret_str;     // Return from send_str
   report_state_t          ret_char;    // Return from send_char
   logic [3:0]             item_cnt;    // Hex digits or joypad keys done
   logic [`BOARD_ID_W-1:0] board_shift;
   logic [`JOY_KEYS-1:0]   joy_keys;

   function automatic logic [`CHAR_W-1:0] hex_char(input logic [3:0] nib);
      return (nib < 4'd10) ? 8'h30 + 8'(nib) : 8'h37 + 8'(nib);
   endfunction

   function automatic logic [`CHAR_W-1:0] joy_char(input logic [3:0] idx,
                                                   input logic [`JOY_KEYS-1:0] keys);
      logic [3:0] key_bit;
      key_bit = KEY_BITS[4 * (`JOY_KEYS - 1 - idx) +: 4];
      return keys[key_bit] ? KEY_LETTERS[`CHAR_W * (`JOY_KEYS - 1 - idx) +: `CHAR_W]
                           : `CODE_SPACE;
   endfunction

   // Busy wins over the result
   function automatic msg_id_t status_msg(input logic test_busy, input logic test_ok);
      return test_busy ? msg_wait : (test_ok ? msg_ok : msg_error);
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= rp_clear;   // HOME only on the first pass
         ret_str     <= rp_clear;
         ret_char    <= rp_clear;
         chr_we      <= 1'b0;
         report_done <= 1'b0;
      end else begin
         report_done <= 1'b0;
         case (state)
            rp_clear: begin
               msg_id     <= msg_home;
               char_index <= '0;
               ret_str    <= rp_board;
               state      <= send_str;
            end
            rp_board: begin
               board_shift <= board_id;
               item_cnt    <= 4'd0;
               msg_id      <= msg_board;
               char_index  <= '0;
               ret_str     <= rp_board_hex;
               state       <= send_str;
            end
            rp_board_hex: begin
               if (item_cnt == 4'd4) begin
                  state <= rp_mem;
               end else begin
                  chr         <= hex_char(board_shift[`BOARD_ID_W-1 -: 4]);
                  board_shift <= board_shift << 4;   // Next digit to the top
                  item_cnt    <= item_cnt + 4'd1;
                  ret_char    <= rp_board_hex;
                  state       <= send_char;
               end
            end
            rp_mem: begin
               msg_id     <= msg_mem;
               char_index <= '0;
               ret_str    <= rp_mem_status;
               state      <= send_str;
            end
            rp_mem_status: begin
               msg_id     <= status_msg(mem_busy, mem_ok);
               char_index <= '0;
               ret_str    <= rp_sd;
               state      <= send_str;
            end
            rp_sd: begin
               msg_id     <= msg_sd;
               char_index <= '0;
               ret_str    <= rp_sd_status;
               state      <= send_str;
            end
            rp_sd_status: begin
               msg_id     <= status_msg(sd_busy, sd_ok);
               char_index <= '0;
               ret_str    <= rp_joy;
               state      <= send_str;
            end
            rp_joy: begin
               joy_keys   <= joy_md;
               item_cnt   <= 4'd0;
               msg_id     <= msg_joy;
               char_index <= '0;
               ret_str    <= rp_joy_keys;
               state      <= send_str;
            end
            rp_joy_keys: begin
               if (item_cnt == 4'(`JOY_KEYS)) begin
                  state <= rp_done;
               end else begin
                  chr      <= joy_char(item_cnt, joy_keys);
                  item_cnt <= item_cnt + 4'd1;
                  ret_char <= rp_joy_keys;
                  state    <= send_char;
               end
            end
            rp_done: begin
               report_done <= 1'b1;
               state       <= rp_board;
            end

            //////////////////////////////////////////////////////////////////////
            // Subroutines
            //////////////////////////////////////////////////////////////////////
            send_str: state <= send_str_next;    // ROM lookup in flight
            send_str_next: begin
               if (msg_char == `MSG_END) begin
                  state <= ret_str;
               end else begin
                  chr        <= msg_char;
                  char_index <= char_index + 1'b1;
                  ret_char   <= send_str;
                  state      <= send_char;
               end
            end
            send_char: begin
               if (!busy) begin
                  chr_we <= 1'b1;
                  state  <= send_char_wait;
               end
            end
            send_char_wait: begin
               chr_we <= 1'b0;
               state  <= ret_char;
            end
            default: state <= rp_clear;
         endcase
      end
   end

   // Strobe only lands on an idle teletype
   chr_we_idle_a: assert property (@(posedge clk) disable iff (reset)
      $rose(chr_we) |-> !busy);

endmodule

// ==== design/screen_buffer.sv ====
`include "status_consts.svh"

module screen_buffer (
   input  logic                    clk,
   input  logic [`CELL_ADDR_W-1:0] write_addr,
   input  logic [`CHAR_W-1:0]      write_data,
   input  logic                    write_en,
   input  logic [`CELL_ADDR_W-1:0] read_addr,
   output logic [`CHAR_W-1:0]      read_data
);

   // One character per cell, 32 x 19
   logic [`CHAR_W-1:0] cells [0:`SCREEN_CELLS-1];

   always_ff @(posedge clk) begin
      if (write_en) begin
         cells[write_addr] <= write_data;
      end
   end

   // Registered read for the display side
   always_ff @(posedge clk) begin
      read_data <= cells[read_addr];
   end

endmodule

// ==== design/status_consts.svh ====
`ifndef STATUS_CONSTS_SVH
`define STATUS_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Screen geometry
//////////////////////////////////////////////////////////////////////
`define SCREEN_COLS  32
`define SCREEN_ROWS  19
`define SCREEN_CELLS 608
`define CELL_ADDR_W  10                   // Row in [9:5], column in [4:0]
`define CHAR_W       8

// Teletype control codes
`define CODE_AT      8'd22
`define CODE_HOME    8'd12
`define CODE_SPACE   8'd32
`define MSG_END      8'hFF                // String terminator

//////////////////////////////////////////////////////////////////////
// Page layout
//////////////////////////////////////////////////////////////////////
`define ROW_BOARD    2
`define ROW_MEM      4
`define ROW_SD       5
`define ROW_JOY      6
`define LINE_COL     2                    // Label column of every line
`define LABEL_COL    10                   // Value text starts here

// Padded label length, and one ROM slot with AT prefix and terminator
`define MSG_LEN      (`LABEL_COL - `LINE_COL)
`define MSG_SLOT     16
`define MSG_IDX_W    $clog2(`MSG_SLOT)

`define BOARD_ID_W   16
`define JOY_KEYS     12

`endif

// ==== design/status_pkg.sv ====
package status_pkg;

   // Teletype command interpreter
   typedef enum logic [2:0] {
      tty_idle,
      tty_command,
      tty_at_row,
      tty_at_col,
      tty_clear,
      tty_put
   } tty_state_t;

   // Page writer with the two shared subroutines at the end
   typedef enum logic [4:0] {
      rp_clear, rp_board, rp_board_hex,
      rp_mem, rp_mem_status,
      rp_sd, rp_sd_status,
      rp_joy, rp_joy_keys, rp_done,
      send_str, send_str_next,
      send_char, send_char_wait
   } report_state_t;

   // Message slots of the text ROM
   typedef enum logic [3:0] {
      msg_home, msg_board, msg_mem, msg_sd, msg_joy,
      msg_wait, msg_ok, msg_error
   } msg_id_t;

endpackage

// ==== design/status_screen.sv ====
`include "status_consts.svh"

module status_screen (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`BOARD_ID_W-1:0]  board_id,
   input  logic                    mem_busy,
   input  logic                    mem_ok,
   input  logic                    sd_busy,
   input  logic                    sd_ok,
   input  logic [`JOY_KEYS-1:0]    joy_md,
   input  logic [`CELL_ADDR_W-1:0] read_addr,
   output logic [`CHAR_W-1:0]      read_data,
   output logic                    report_done
);
   import status_pkg::*;

   msg_id_t                 msg_id;
   logic [`MSG_IDX_W-1:0]   char_index;
   logic [`CHAR_W-1:0]      msg_char;
   logic [`CHAR_W-1:0]      chr;
   logic                    chr_we;
   logic                    busy;
   logic [`CELL_ADDR_W-1:0] write_addr;
   logic [`CHAR_W-1:0]      write_data;
   logic                    write_en;

   report_sequencer i_sequencer (
      .clk, .reset, .board_id, .mem_busy, .mem_ok, .sd_busy, .sd_ok, .joy_md,
      .busy, .msg_char, .msg_id, .char_index, .chr, .chr_we, .report_done
   );

   message_rom i_rom (.clk, .msg_id, .char_index, .msg_char);

   teletype i_tty (.clk, .reset, .chr, .chr_we, .busy, .write_addr, .write_data, .write_en);

   // Second port goes out to the display controller
   screen_buffer i_buffer (.clk, .write_addr, .write_data, .write_en, .read_addr, .read_data);

endmodule

// ==== design/teletype.sv ====
`include "status_consts.svh"

module teletype (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`CHAR_W-1:0]      chr,
   input  logic                    chr_we,
   output logic                    busy,
   output logic [`CELL_ADDR_W-1:0] write_addr,
   output logic [`CHAR_W-1:0]      write_data,
   output logic                    write_en
);
   import status_pkg::*;

   tty_state_t          state;
   logic [`CHAR_W-1:0]  data;    // Byte under interpretation
   logic [4:0]          row;

   // write_addr doubles as the cursor
   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= tty_idle;
         busy       <= 1'b0;
         write_en   <= 1'b0;
         write_addr <= '0;
      end else begin
         case (state)
            tty_idle, tty_at_row, tty_at_col: begin
               if (chr_we) begin
                  data <= chr;
                  if (state == tty_at_row) begin
                     row   <= chr[4:0];
                     state <= tty_at_col;
                  end else if (state == tty_at_col) begin
                     write_addr <= {row, chr[4:0]};
                     state      <= tty_idle;
                  end else begin
                     busy  <= 1'b1;
                     state <= tty_command;
                  end
               end
            end
            tty_command: begin
               if (data == `CODE_AT) begin
                  busy  <= 1'b0;              // Row and column follow unbusied
                  state <= tty_at_row;
               end else if (data == `CODE_HOME) begin
                  write_addr <= '0;
                  write_data <= `CODE_SPACE;
                  write_en   <= 1'b1;
                  state      <= tty_clear;
               end else begin
                  write_data <= data;
                  write_en   <= 1'b1;
                  state      <= tty_put;
               end
            end
            tty_clear: begin
               if (write_addr == `CELL_ADDR_W'(`SCREEN_CELLS - 1)) begin
                  busy       <= 1'b0;
                  write_en   <= 1'b0;
                  write_addr <= '0;           // Cursor home
                  state      <= tty_idle;
               end else begin
                  write_addr <= write_addr + 1'b1;
               end
            end
            tty_put: begin
               write_en   <= 1'b0;
               busy       <= 1'b0;
               write_addr <= write_addr + 1'b1;
               state      <= tty_idle;
            end
            default: state <= tty_idle;
         endcase
      end
   end

   // AT positions from the ROM must stay on screen
   write_in_screen_a: assert property (@(posedge clk) disable iff (reset)
      write_en |-> write_addr < `CELL_ADDR_W'(`SCREEN_CELLS));

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_status_screen \
   -Mdir obj_dir -o tb_sim \
   && ./obj_dir/tb_sim | tee /dev/stderr | grep -F "Done: no errors" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== tb.f ====
+incdir+design
design/status_pkg.sv
design/message_rom.sv
design/report_sequencer.sv
design/teletype.sv
design/screen_buffer.sv
design/status_screen.sv
tb/screen_checker.sv
tb/tb_status_screen.sv

// ==== tb/screen_checker.sv ====
`include "status_consts.svh"

module screen_checker (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`BOARD_ID_W-1:0]  board_id,
   input  logic                    mem_busy,
   input  logic                    mem_ok,
   input  logic                    sd_busy,
   input  logic                    sd_ok,
   input  logic [`JOY_KEYS-1:0]    joy_md,
   input  logic [`CELL_ADDR_W-1:0] read_addr,
   input  logic                    read_valid,
   input  logic [`CHAR_W-1:0]      read_data,
   input  logic                    report_done,
   output int                      error_count,
   output int                      cell_count
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_GAP = 2000;
   // joy_md bit behind each key slot from left to right
   localparam int KEY_BIT [`JOY_KEYS] = '{0, 1, 2, 3, 4, 5, 6, 10, 9, 8, 7, 11};

   logic [`CELL_ADDR_W-1:0] addr_q;
   logic [`CHAR_W-1:0]      expect_q;
   logic                    valid_q;
   logic                    seen_done;   // First pass finished
   int                      gap;

   function automatic logic [7:0] text_at(input string text, input int pos);
      logic [7:0] c;
      c = `CODE_SPACE;
      if (pos >= 0 && pos < text.len()) c = text[pos];
      return c;
   endfunction

   function automatic logic [7:0] hex_digit(input logic [3:0] nib);
      logic [7:0] c;
      if (nib < 4'd10) c = "0" + {4'd0, nib};
      else c = "A" + {4'd0, nib} - 8'd10;
      return c;
   endfunction

   function automatic string status_text(input logic test_busy, input logic test_ok);
      return test_busy ? "wait " : (test_ok ? "OK   " : "ERROR");
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Page model
   //////////////////////////////////////////////////////////////////////
   function automatic logic [7:0] model_cell(input logic [`CELL_ADDR_W-1:0] addr);
      int         row;
      int         col;
      int         off;
      string      keys;
      logic [7:0] c;
      row  = int'(addr) / `SCREEN_COLS;
      col  = int'(addr) % `SCREEN_COLS;
      off  = col - `LABEL_COL;             // Position inside the value text
      keys = "UDLR123XYZSM";
      c    = `CODE_SPACE;
      if (off < 0) begin
         case (row)
            `ROW_BOARD: c = text_at("BOARD", col - `LINE_COL);
            `ROW_MEM:   c = text_at("MEM", col - `LINE_COL);
            `ROW_SD:    c = text_at("SD", col - `LINE_COL);
            `ROW_JOY:   c = text_at("JOY1", col - `LINE_COL);
            default: ;
         endcase
      end else begin
         case (row)
            `ROW_BOARD: if (off < 4) c = hex_digit(board_id[4 * (3 - off) +: 4]);
            `ROW_MEM:   c = text_at(status_text(mem_busy, mem_ok), off);
            `ROW_SD:    c = text_at(status_text(sd_busy, sd_ok), off);
            `ROW_JOY:   if (off < `JOY_KEYS && joy_md[KEY_BIT[off]]) c = keys[off];
            default: ;
         endcase
      end
      return c;
   endfunction

   always @(posedge clk) begin
      if (reset) begin
         valid_q   <= 1'b0;
         seen_done <= 1'b0;
         gap = 0;
      end else begin
         valid_q  <= read_valid;           // read_data follows one cycle later
         addr_q   <= read_addr;
         expect_q <= model_cell(read_addr);
         if (valid_q) begin
            cell_count++;
            if (read_data !== expect_q) begin
               $display("Fail read_data at cell %h: expected %h, got %h",
                        addr_q, expect_q, read_data);
               error_count++;
            end
         end
         if (report_done) begin
            seen_done <= 1'b1;
            gap = 0;
         end else if (seen_done) begin
            gap++;
            if (gap == MAX_GAP) begin
               $display("report_done did not pulse within %0d cycles", MAX_GAP);
               error_count++;
               gap = 0;
            end
         end
      end
   end

endmodule

// ==== tb/tb_status_screen.sv ====
`include "status_consts.svh"

module tb_status_screen;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ROUNDS      = 20;
   localparam int PASS_CYCLES = 2000;   // Upper bound for one page pass
   localparam int CLK_PERIOD  = 40;
   localparam int WATCHDOG_NS = (ROUNDS + 2) * 3 * PASS_CYCLES * CLK_PERIOD;

   logic                    clk;
   logic                    reset;
   logic [`BOARD_ID_W-1:0]  board_id;
   logic                    mem_busy;
   logic                    mem_ok;
   logic                    sd_busy;
   logic                    sd_ok;
   logic [`JOY_KEYS-1:0]    joy_md;
   logic [`CELL_ADDR_W-1:0] read_addr;
   logic [`CHAR_W-1:0]      read_data;
   logic                    report_done;
   logic                    read_valid;     // Marks addresses the checker compares
   logic [31:0]             lfsr;
   int                      check_errors;
   int                      cell_count;

   status_screen i_dut (
      .clk, .reset, .board_id, .mem_busy, .mem_ok, .sd_busy, .sd_ok, .joy_md,
      .read_addr, .read_data, .report_done
   );

   screen_checker i_checker (
      .clk, .reset, .board_id, .mem_busy, .mem_ok, .sd_busy, .sd_ok, .joy_md,
      .read_addr, .read_valid, .read_data, .report_done,
      .error_count(check_errors), .cell_count
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Random source
   //////////////////////////////////////////////////////////////////////
   // Taps 32, 22, 2, 1
   function automatic logic [31:0] next_lfsr(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
   endfunction

   task automatic take_random(input int n, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsr  = next_lfsr(lfsr);
         value = {value[30:0], lfsr[0]};   // One step per bit
      end
   endtask

   task automatic wait_report();
      @(posedge clk);
      while (!report_done) @(posedge clk);
   endtask

   // New inputs for one round
   // Rounds 0 and 1 take the all-zero and all-ones corners
   task automatic load_round(input int round);
      logic [31:0] bits;
      #2;
      take_random(`BOARD_ID_W, bits);
      board_id = (round == 0) ? '0 : (round == 1) ? '1 : bits[`BOARD_ID_W-1:0];
      take_random(`JOY_KEYS, bits);
      joy_md   = (round == 0) ? '0 : (round == 1) ? '1 : bits[`JOY_KEYS-1:0];
      mem_busy = round[0];                 // Every busy and ok pair within 8 rounds
      mem_ok   = round[1];
      sd_busy  = round[1];
      sd_ok    = round[2];
   endtask

   task automatic read_screen();
      for (int a = 0; a < `SCREEN_CELLS; a++) begin
         #2;
         read_addr  = `CELL_ADDR_W'(a);
         read_valid = 1'b1;
         @(posedge clk);
      end
      #2 read_valid = 1'b0;
      repeat (2) @(posedge clk);           // Last compare lands here
   endtask

   initial begin
      int total;
      clk        = 1'b0;
      reset      = 1'b1;
      board_id   = '0;
      mem_busy   = 1'b0;
      mem_ok     = 1'b0;
      sd_busy    = 1'b0;
      sd_ok      = 1'b0;
      joy_md     = '0;
      read_addr  = '0;
      read_valid = 1'b0;
      lfsr       = 32'h5114;
      repeat (3) @(posedge clk);
      #2 reset = 1'b0;
      wait_report();                       // First pass includes the HOME clear
      for (int r = 0; r < ROUNDS; r++) begin
         load_round(r);
         wait_report();                    // Pass that mixes old and new inputs
         wait_report();
         read_screen();
         wait_report();
      end
      total = check_errors;
      if (cell_count != ROUNDS * `SCREEN_CELLS) begin
         $display("Readback compared %0d cells instead of %0d", cell_count,
                  ROUNDS * `SCREEN_CELLS);
         total++;
      end
      $display("Compared %0d cells, %0d errors", cell_count, total);
      if (total == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout after %0d ns, the page passes did not finish", WATCHDOG_NS);
      $display("Done: errors found");
      $finish;
   end

endmodule
